//--- rtl/cpuPkg.sv
package cpuPkg;

    // Bit positions of the control-flag vector
    typedef enum int unsigned {
        dbSrcData = 0,  // Data bus sources
        dbSrcAcc,
        dbSrcX,
        sbSrcAlu,       // Stack bus sources
        sbSrcHold,
        sbSrcAcc,
        dbToSb,         // Bridge DB onto SB
        adlSrcPc,       // Address low bus sources
        sbToAdl,        // Bridge SB onto ADL
        adhSrcPc,       // Address high bus sources
        adhSrcData,
        loadX,
        loadAcc,
        loadHold,
        loadAbl,
        loadAbh,
        loadDor,
        loadPc,         // PC from ADH and ADL
        pcInc,
        aluCarryEn,     // Carry in from status C
        setCv,
        clearC,
        setC,
        memWrite        // Keep last, sets the vector width
    } flagIndexE;

    localparam int FLAG_COUNT = int'(memWrite) + 1;

    typedef logic [FLAG_COUNT-1:0] flagVecT;

    // 6502 encodings of the supported subset
    typedef enum logic [7:0] {
        opLdaImm = 8'hA9,
        opLdxImm = 8'hA2,
        opTax    = 8'hAA,
        opAdcImm = 8'h69,
        opAndImm = 8'h29,
        opOraImm = 8'h09,
        opEorImm = 8'h49,
        opClc    = 8'h18,
        opSec    = 8'h38,
        opStaAbs = 8'h8D,
        opStxAbs = 8'h8E,
        opJmpAbs = 8'h4C,
        opNop    = 8'hEA
    } opcodeE;

    typedef enum logic [2:0] {
        aluAdd,
        aluAnd,
        aluOr,
        aluXor,
        aluPass
    } aluOpE;

    typedef enum logic [2:0] {
        tFetch,
        tOperand,
        tAddrLow,
        tAddrHigh,
        tWrite
    } timingStateE;

endpackage

//--- rtl/controlIf.sv
interface controlIf;
    cpuPkg::flagVecT flags;
    cpuPkg::aluOpE   aluOp;
    logic            carryFlag;
    logic [7:0]      aluResult;
    logic            aluCarry;
    logic            aluOverflow;

    modport seq (output flags, output aluOp);

    // Shared by the datapath and the ALU
    modport dp (
        input  flags, aluOp, carryFlag,
        output aluResult, aluCarry, aluOverflow
    );

    modport psr (input flags, aluCarry, aluOverflow, output carryFlag);
endinterface

//--- rtl/alu.sv
module alu (
    controlIf.dp      ctrl,
    input logic [7:0] operandA,
    input logic [7:0] operandB
);
    logic       carryIn;
    logic [8:0] sum;

    // Only ADC takes the stored carry
    assign carryIn = ctrl.flags[cpuPkg::aluCarryEn] & ctrl.carryFlag;

    assign sum = {1'b0, operandA} + {1'b0, operandB} + {8'd0, carryIn};

    always_comb begin
        case (ctrl.aluOp)
            cpuPkg::aluAdd:
                ctrl.aluResult = sum[7:0];
            cpuPkg::aluAnd:
                ctrl.aluResult = operandA & operandB;
            cpuPkg::aluOr:
                ctrl.aluResult = operandA | operandB;
            cpuPkg::aluXor:
                ctrl.aluResult = operandA ^ operandB;
            default:
                ctrl.aluResult = operandB;  // Pass B
        endcase
    end

    assign ctrl.aluCarry = sum[8];

    // Same-sign operands giving a result of the other sign
    assign ctrl.aluOverflow = (operandA[7] == operandB[7]) && (sum[7] != operandA[7]);

endmodule

//--- rtl/statusRegister.sv
module statusRegister (
    input logic       clk,
    input logic       arstN,
    input logic [7:0] result,
    controlIf.psr     ctrl
);
    logic negative;
    logic zero;
    logic carry;
    logic overflow;
    logic loadSeen;

    // N and Z follow every load of A or X
    assign loadSeen = ctrl.flags[cpuPkg::loadAcc] | ctrl.flags[cpuPkg::loadX];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            negative <= 1'b0;
            zero     <= 1'b0;
        end else if (loadSeen) begin
            negative <= result[7];
            zero     <= (result == 8'd0);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            carry    <= 1'b0;
            overflow <= 1'b0;
        end else if (ctrl.flags[cpuPkg::setCv]) begin
            carry    <= ctrl.aluCarry;
            overflow <= ctrl.aluOverflow;
        end else if (ctrl.flags[cpuPkg::clearC]) begin
            carry <= 1'b0;  // CLC
        end else if (ctrl.flags[cpuPkg::setC]) begin
            carry <= 1'b1;  // SEC
        end
    end

    assign ctrl.carryFlag = carry;

endmodule

//--- rtl/sequencer.sv
module sequencer (
    input logic       clk,
    input logic       arstN,
    input logic [7:0] dataRead,
    controlIf.seq     ctrl
);
    cpuPkg::timingStateE state, nextState;
    cpuPkg::opcodeE      ir;
    cpuPkg::flagVecT     f;

    // Put the PC, optionally stepped, back on the address pins
    function automatic cpuPkg::flagVecT addrFromPc(input logic inc);
        cpuPkg::flagVecT v;
        v = '0;
        v[cpuPkg::pcInc]    = inc;
        v[cpuPkg::adlSrcPc] = 1'b1;
        v[cpuPkg::adhSrcPc] = 1'b1;
        v[cpuPkg::loadAbl]  = 1'b1;
        v[cpuPkg::loadAbh]  = 1'b1;
        return v;
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= cpuPkg::tFetch;
            ir    <= cpuPkg::opNop;
        end else begin
            state <= nextState;
            if (state == cpuPkg::tFetch)
                ir <= cpuPkg::opcodeE'(dataRead);
        end
    end

    always_comb begin
        case (state)
            cpuPkg::tFetch:
                case (dataRead)
                    cpuPkg::opStaAbs, cpuPkg::opStxAbs, cpuPkg::opJmpAbs:
                        nextState = cpuPkg::tAddrLow;
                    default:
                        nextState = cpuPkg::tOperand;
                endcase
            cpuPkg::tAddrLow:
                nextState = cpuPkg::tAddrHigh;
            cpuPkg::tAddrHigh:
                nextState = (ir == cpuPkg::opJmpAbs) ? cpuPkg::tFetch : cpuPkg::tWrite;
            default:
                nextState = cpuPkg::tFetch;  // tOperand and tWrite end the instruction
        endcase
    end

    always_comb begin
        f = '0;
        ctrl.aluOp = cpuPkg::aluPass;
        case (state)
            cpuPkg::tFetch:
                f = addrFromPc(1'b1);
            cpuPkg::tOperand: begin
                case (ir)
                    cpuPkg::opTax: begin
                        f[cpuPkg::sbSrcAcc] = 1'b1;
                        f[cpuPkg::loadX]    = 1'b1;
                    end
                    cpuPkg::opClc:
                        f[cpuPkg::clearC] = 1'b1;
                    cpuPkg::opSec:
                        f[cpuPkg::setC] = 1'b1;
                    cpuPkg::opLdxImm: begin
                        f = addrFromPc(1'b1);
                        f[cpuPkg::dbSrcData] = 1'b1;
                        f[cpuPkg::dbToSb]    = 1'b1;
                        f[cpuPkg::loadX]     = 1'b1;
                    end
                    cpuPkg::opLdaImm, cpuPkg::opAdcImm, cpuPkg::opAndImm,
                    cpuPkg::opOraImm, cpuPkg::opEorImm: begin
                        f = addrFromPc(1'b1);
                        f[cpuPkg::dbSrcData] = 1'b1;
                        f[cpuPkg::sbSrcAlu]  = 1'b1;
                        f[cpuPkg::loadAcc]   = 1'b1;
                        case (ir)
                            cpuPkg::opAdcImm: begin
                                ctrl.aluOp            = cpuPkg::aluAdd;
                                f[cpuPkg::aluCarryEn] = 1'b1;
                                f[cpuPkg::setCv]      = 1'b1;
                            end
                            cpuPkg::opAndImm:
                                ctrl.aluOp = cpuPkg::aluAnd;
                            cpuPkg::opOraImm:
                                ctrl.aluOp = cpuPkg::aluOr;
                            cpuPkg::opEorImm:
                                ctrl.aluOp = cpuPkg::aluXor;
                            default:
                                ctrl.aluOp = cpuPkg::aluPass;  // LDA
                        endcase
                    end
                    default: ;  // NOP and unknown codes idle for a cycle
                endcase
            end
            cpuPkg::tAddrLow: begin
                f = addrFromPc(1'b1);
                f[cpuPkg::dbSrcData] = 1'b1;
                f[cpuPkg::loadHold]  = 1'b1;  // Low target byte parks in the hold register
            end
            cpuPkg::tAddrHigh: begin
                f[cpuPkg::adhSrcData] = 1'b1;
                f[cpuPkg::sbSrcHold]  = 1'b1;
                f[cpuPkg::sbToAdl]    = 1'b1;
                f[cpuPkg::loadAbl]    = 1'b1;
                f[cpuPkg::loadAbh]    = 1'b1;
                if (ir == cpuPkg::opJmpAbs) begin
                    f[cpuPkg::loadPc] = 1'b1;
                end else begin
                    f[cpuPkg::pcInc]   = 1'b1;
                    f[cpuPkg::loadDor] = 1'b1;
                    if (ir == cpuPkg::opStxAbs)
                        f[cpuPkg::dbSrcX] = 1'b1;
                    else
                        f[cpuPkg::dbSrcAcc] = 1'b1;
                end
            end
            cpuPkg::tWrite: begin
                f = addrFromPc(1'b0);  // Next fetch address, PC already stepped
                f[cpuPkg::memWrite] = 1'b1;
            end
            default: ;
        endcase
    end

    assign ctrl.flags = f;

    legalState: assert property (@(posedge clk) disable iff (!arstN)
        state inside {cpuPkg::tFetch, cpuPkg::tOperand, cpuPkg::tAddrLow,
                      cpuPkg::tAddrHigh, cpuPkg::tWrite});

    writeOnlyInWriteState: assert property (@(posedge clk) disable iff (!arstN)
        f[cpuPkg::memWrite] |-> state == cpuPkg::tWrite);

endmodule

//--- rtl/internalDataflow.sv
module internalDataflow (
    input  logic        clk,
    input  logic        arstN,
    input  logic [7:0]  dataRead,
    output logic [15:0] address,
    output logic [7:0]  dataWrite,
    output logic        writeStrobe,
    output logic [7:0]  aluOperandA,
    output logic [7:0]  aluOperandB,
    output logic [7:0]  loadValue,
    controlIf.dp        ctrl
);
    cpuPkg::flagVecT f;

    // Register file
    logic [7:0] xReg, accReg, aluHoldReg;
    logic [7:0] pchReg, pclReg;
    logic [7:0] abhReg, ablReg, dorReg;

    // Internal buses
    logic [7:0] dataBus, stackBus, addressLowBus, addressHighBus;

    logic [15:0] pcIncremented;

    assign f = ctrl.flags;

    assign pcIncremented = {pchReg, pclReg} + {15'd0, f[cpuPkg::pcInc]};

    // An undriven bus reads as all ones, like the precharged 6502 buses
    always_comb begin
        dataBus = 8'hFF;
        if (f[cpuPkg::dbSrcData])
            dataBus = dataRead;
        else if (f[cpuPkg::dbSrcAcc])
            dataBus = accReg;
        else if (f[cpuPkg::dbSrcX])
            dataBus = xReg;
    end

    always_comb begin
        stackBus = 8'hFF;
        if (f[cpuPkg::sbSrcAlu])
            stackBus = ctrl.aluResult; // ALU result straight onto SB
        else if (f[cpuPkg::sbSrcHold])
            stackBus = aluHoldReg;
        else if (f[cpuPkg::sbSrcAcc])
            stackBus = accReg;
        else if (f[cpuPkg::dbToSb])
            stackBus = dataBus;
    end

    always_comb begin
        addressLowBus = 8'hFF;
        if (f[cpuPkg::adlSrcPc])
            addressLowBus = pcIncremented[7:0];
        else if (f[cpuPkg::sbToAdl])
            addressLowBus = stackBus;
    end

    always_comb begin
        addressHighBus = 8'hFF;
        if (f[cpuPkg::adhSrcPc])
            addressHighBus = pcIncremented[15:8];
        else if (f[cpuPkg::adhSrcData])
            addressHighBus = dataRead;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            xReg       <= 8'd0;
            accReg     <= 8'd0;
            aluHoldReg <= 8'd0;
        end else begin
            if (f[cpuPkg::loadX])
                xReg <= stackBus;
            if (f[cpuPkg::loadAcc])
                accReg <= stackBus;
            if (f[cpuPkg::loadHold])
                aluHoldReg <= ctrl.aluResult;
        end
    end

    // Jump target has priority over the incrementer
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pchReg <= 8'd0;
            pclReg <= 8'd0;
        end else if (f[cpuPkg::loadPc]) begin
            pchReg <= addressHighBus;
            pclReg <= addressLowBus;
        end else begin
            pchReg <= pcIncremented[15:8];
            pclReg <= pcIncremented[7:0];
        end
    end

    // Address and data output registers
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            abhReg <= 8'd0;
            ablReg <= 8'd0;
            dorReg <= 8'd0;
        end else begin
            if (f[cpuPkg::loadAbh])
                abhReg <= addressHighBus;
            if (f[cpuPkg::loadAbl])
                ablReg <= addressLowBus;
            if (f[cpuPkg::loadDor])
                dorReg <= dataBus;
        end
    end

    assign address     = {abhReg, ablReg};
    assign dataWrite   = dorReg;
    assign writeStrobe = f[cpuPkg::memWrite];

    assign aluOperandA = accReg;
    assign aluOperandB = dataBus;
    assign loadValue   = stackBus;  // Value seen by X and A loads

    // Sequencer decode must never fight over a bus
    busSourceOneHot: assert property (@(posedge clk) disable iff (!arstN)
        $onehot0({f[cpuPkg::dbSrcData], f[cpuPkg::dbSrcAcc], f[cpuPkg::dbSrcX]}) &&
        $onehot0({f[cpuPkg::sbSrcAlu], f[cpuPkg::sbSrcHold],
                  f[cpuPkg::sbSrcAcc], f[cpuPkg::dbToSb]}) &&
        $onehot0({f[cpuPkg::adlSrcPc], f[cpuPkg::sbToAdl]}) &&
        $onehot0({f[cpuPkg::adhSrcPc], f[cpuPkg::adhSrcData]}));

endmodule

//--- rtl/cpuCore.sv
module cpuCore (
    input  logic        clk,
    input  logic        arstN,
    output logic [15:0] address,
    input  logic [7:0]  dataRead,
    output logic [7:0]  dataWrite,
    output logic        writeStrobe
);
    logic [7:0] accToAlu;
    logic [7:0] dataBusToAlu;
    logic [7:0] loadValue;

    controlIf ctrl ();

    sequencer sequencer (
        .clk      (clk),
        .arstN    (arstN),
        .dataRead (dataRead),
        .ctrl     (ctrl.seq)
    );

    internalDataflow datapath (
        .clk         (clk),
        .arstN       (arstN),
        .dataRead    (dataRead),
        .address     (address),
        .dataWrite   (dataWrite),
        .writeStrobe (writeStrobe),
        .aluOperandA (accToAlu),
        .aluOperandB (dataBusToAlu),
        .loadValue   (loadValue),
        .ctrl        (ctrl.dp)
    );

    alu alu (
        .ctrl     (ctrl.dp),
        .operandA (accToAlu),
        .operandB (dataBusToAlu)
    );

    statusRegister psr (
        .clk    (clk),
        .arstN  (arstN),
        .result (loadValue),
        .ctrl   (ctrl.psr)
    );

endmodule

//--- tests/cpuCoreTb.sv
module cpuCoreTb;

    localparam int NUM_TESTS     = 9;
    localparam int MAX_BYTES     = 16;
    localparam int RESET_CYCLES  = 10;
    localparam int STORE_TIMEOUT = 200;
    localparam int SETTLE_CYCLES = 30;

    localparam logic [15:0] TRAP_ADDR = 16'h0300;  // Target of the store skipped by JMP

    // 6502 encodings
    localparam logic [7:0] LDA_IMM = 8'hA9;
    localparam logic [7:0] LDX_IMM = 8'hA2;
    localparam logic [7:0] TAX     = 8'hAA;
    localparam logic [7:0] ADC_IMM = 8'h69;
    localparam logic [7:0] AND_IMM = 8'h29;
    localparam logic [7:0] ORA_IMM = 8'h09;
    localparam logic [7:0] EOR_IMM = 8'h49;
    localparam logic [7:0] CLC     = 8'h18;
    localparam logic [7:0] SEC     = 8'h38;
    localparam logic [7:0] STA_ABS = 8'h8D;
    localparam logic [7:0] STX_ABS = 8'h8E;
    localparam logic [7:0] JMP_ABS = 8'h4C;
    localparam logic [7:0] NOP     = 8'hEA;

    logic        clk = 1'b0;
    logic        arstN;
    logic [15:0] address;
    logic [7:0]  dataRead;
    logic [7:0]  dataWrite;
    logic        writeStrobe;

    logic [7:0]  mem [65536];
    logic [15:0] logAddr [$];

    // Stimulus and expected values with one row per test
    string       testName    [NUM_TESTS];
    logic [7:0]  body        [NUM_TESTS][MAX_BYTES];
    int          bodyLen     [NUM_TESTS];
    logic [15:0] jumpTarget  [NUM_TESTS];  // Zero when the body starts at address zero
    logic [15:0] storeAddr   [NUM_TESTS];
    logic [7:0]  expectValue [NUM_TESTS];
    int          expectCycle [NUM_TESTS];  // Strobe cycle counted from the first fetch as 1

    int          cur;
    logic [31:0] rngState;
    int          passCount;
    int          failCount;

    cpuCore UUT (
        .clk         (clk),
        .arstN       (arstN),
        .address     (address),
        .dataRead    (dataRead),
        .dataWrite   (dataWrite),
        .writeStrobe (writeStrobe)
    );

    always #2 clk = ~clk;

    assign dataRead = mem[address];  // Same-cycle read

    function automatic logic [7:0] randomByte();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState[7:0];
    endfunction

    function automatic logic [7:0] fillByte(input logic [15:0] addr);
        return addr[15:8] ^ {addr[6:0], addr[7]} ^ 8'h3C;
    endfunction

    // Instruction-level model of A, X and C from reset with the cycle count
    task automatic modelEntry(input int idx);
        logic [7:0] a;
        logic [7:0] x;
        logic [7:0] op;
        logic [7:0] imm;
        logic [8:0] sum;
        logic       c;
        logic       done;
        int         k;
        int         len;
        int         cycles;
        a = 8'd0;
        x = 8'd0;
        c = 1'b0;
        done = 1'b0;
        k = 0;
        cycles = (jumpTarget[idx] != 16'h0000) ? 3 : 0;
        while (!done && k < bodyLen[idx]) begin
            op = body[idx][k];
            imm = body[idx][k+1];
            len = 2;
            cycles += 2;
            case (op)
                LDA_IMM: a = imm;
                LDX_IMM: x = imm;
                AND_IMM: a = a & imm;
                ORA_IMM: a = a | imm;
                EOR_IMM: a = a ^ imm;
                ADC_IMM: begin
                    sum = {1'b0, a} + {1'b0, imm} + {8'd0, c};
                    a = sum[7:0];
                    c = sum[8];
                end
                TAX: x = a;
                CLC: c = 1'b0;
                SEC: c = 1'b1;
                STA_ABS, STX_ABS: begin
                    expectValue[idx] = (op == STA_ABS) ? a : x;
                    cycles += 2;  // Absolute store takes four
                    done = 1'b1;
                end
                default: ;  // NOP
            endcase
            if (op inside {TAX, CLC, SEC, NOP})
                len = 1;
            k += len;
        end
        expectCycle[idx] = cycles;
    endtask

    task automatic emitByte(input logic [7:0] b);
        body[cur][bodyLen[cur]] = b;
        bodyLen[cur]++;
    endtask

    task automatic emitImm(input logic [7:0] op, input logic [7:0] value);
        emitByte(op);
        emitByte(value);
    endtask

    task automatic emitStore(input logic [7:0] op, input logic [15:0] target);
        emitByte(op);
        emitByte(target[7:0]);
        emitByte(target[15:8]);
        storeAddr[cur] = target;
    endtask

    task automatic startTest(input string name, input logic [15:0] target);
        testName[cur] = name;
        bodyLen[cur] = 0;
        jumpTarget[cur] = target;
    endtask

    task automatic endTest();
        modelEntry(cur);
        cur++;
    endtask

    task automatic buildTable();
        rngState = 32'd72032;
        cur = 0;
        startTest("lda sta", 16'h0000);
        emitImm(LDA_IMM, randomByte());
        emitStore(STA_ABS, 16'h0200);
        endTest();
        startTest("and", 16'h0000);
        emitImm(LDA_IMM, randomByte());
        emitImm(AND_IMM, randomByte());
        emitStore(STA_ABS, 16'h0201);
        endTest();
        startTest("ora", 16'h0000);
        emitImm(LDA_IMM, randomByte());
        emitImm(ORA_IMM, randomByte());
        emitStore(STA_ABS, 16'h0202);
        endTest();
        startTest("eor", 16'h0000);
        emitImm(LDA_IMM, randomByte());
        emitImm(EOR_IMM, randomByte());
        emitStore(STA_ABS, 16'h0203);
        endTest();
        // Carry set first so that CLC has a bit to clear
        // Both top bits set so the first sum carries into the second ADC
        startTest("clc adc adc", 16'h0000);
        emitByte(SEC);
        emitByte(CLC);
        emitImm(LDA_IMM, randomByte() | 8'h80);
        emitImm(ADC_IMM, randomByte() | 8'h80);
        emitImm(ADC_IMM, randomByte());
        emitStore(STA_ABS, 16'h0204);
        endTest();
        startTest("sec adc", 16'h0000);
        emitByte(SEC);
        emitImm(LDA_IMM, randomByte());
        emitImm(ADC_IMM, randomByte());
        emitStore(STA_ABS, 16'hC3A5);
        endTest();
        startTest("tax stx", 16'h0000);
        emitImm(LDA_IMM, randomByte());
        emitByte(NOP);
        emitByte(TAX);
        emitStore(STX_ABS, 16'h0206);
        endTest();
        startTest("ldx stx", 16'h0000);
        emitImm(LDX_IMM, randomByte());
        emitStore(STX_ABS, 16'h0207);
        endTest();
        startTest("jmp far", 16'h8130);
        emitImm(LDA_IMM, randomByte());
        emitStore(STA_ABS, 16'h0208);
        endTest();
    endtask

    task automatic loadProgram(input int idx);
        int          a;
        int          k;
        logic [15:0] base;
        logic [15:0] selfAddr;
        for (a = 0; a < 65536; a++)
            mem[a] = fillByte(16'(a));
        base = jumpTarget[idx];
        if (base != 16'h0000) begin
            mem[0] = JMP_ABS;
            mem[1] = base[7:0];
            mem[2] = base[15:8];
            mem[3] = STA_ABS;  // Must never execute
            mem[4] = TRAP_ADDR[7:0];
            mem[5] = TRAP_ADDR[15:8];
        end
        for (k = 0; k < bodyLen[idx]; k++)
            mem[base + 16'(k)] = body[idx][k];
        selfAddr = base + 16'(bodyLen[idx]);
        mem[selfAddr]         = JMP_ABS;  // Park on a jump to itself
        mem[selfAddr + 16'd1] = selfAddr[7:0];
        mem[selfAddr + 16'd2] = selfAddr[15:8];
    endtask

    task automatic applyReset(input int idx);
        @(posedge clk);
        arstN <= 1'b0;
        loadProgram(idx);
        logAddr.delete();
        repeat (RESET_CYCLES) @(posedge clk);
        arstN <= 1'b1;
    endtask

    // One cycle sampled mid-cycle where the pins are stable
    task automatic sampleCycle();
        @(negedge clk);
        if (writeStrobe) begin
            mem[address] = dataWrite;
            logAddr.push_back(address);
        end
    endtask

    task automatic runEntry(input int idx);
        int   cycle;
        int   errors;
        logic seen;
        cycle = 0;
        errors = 0;
        seen = 1'b0;
        applyReset(idx);
        while (!seen && cycle < STORE_TIMEOUT) begin
            sampleCycle();
            cycle++;
            if (cycle == 1) begin
                assert (address == 16'h0000 && !writeStrobe) else begin
                    $display("ERR %0t: after reset address %04h strobe %b, expected 0000 and 0",
                             $time, address, writeStrobe);
                    errors++;
                end
            end
            seen = writeStrobe;
        end
        assert (seen) else begin
            $display("Test %0d timed out: the store never happened within %0d cycles",
                     idx, STORE_TIMEOUT);
            errors++;
        end
        if (seen) begin
            assert (address == storeAddr[idx]) else begin
                $display("ERR %0t: store address %04h, expected %04h",
                         $time, address, storeAddr[idx]);
                errors++;
            end
            assert (dataWrite == expectValue[idx]) else begin
                $display("ERR %0t: stored %02h, expected %02h",
                         $time, dataWrite, expectValue[idx]);
                errors++;
            end
            assert (cycle == expectCycle[idx]) else begin
                $display("ERR %0t: strobe in cycle %0d, expected cycle %0d",
                         $time, cycle, expectCycle[idx]);
                errors++;
            end
            repeat (SETTLE_CYCLES) sampleCycle();  // A stray store would land in the log
            assert (logAddr.size() == 1) else begin
                $display("Test %0d wrote memory %0d times where one store was expected",
                         idx, logAddr.size());
                errors++;
            end
        end
        if (errors == 0)
            passCount++;
        else
            failCount++;
        $display("Test %0d %s %s", idx, testName[idx], (errors == 0) ? "ok" : "bad");
    endtask

    initial begin
        int i;
        arstN <= 1'b0;
        passCount = 0;
        failCount = 0;
        buildTable();
        for (i = 0; i < NUM_TESTS; i++)
            runEntry(i);
        $display("Tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- cpuCore.f
rtl/cpuPkg.sv
rtl/controlIf.sv
rtl/alu.sv
rtl/statusRegister.sv
rtl/sequencer.sv
rtl/internalDataflow.sv
rtl/cpuCore.sv
tests/cpuCoreTb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= cpuCoreTb
FILELIST  ?= cpuCore.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
